// ==== hw/csr_settings.svh ====
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// data path and index widths
`define CSR_XLEN 32
`define CSR_IDX_W 12

// mcycle, split over mcycle and mcycleh
`define CSR_CYCLE_W 64

// mstatus fields
`define MSTATUS_MIE_BIT 3
`define MSTATUS_MPIE_BIT 7

// low bit of the two-bit MPP field, hardwired to machine mode
`define MSTATUS_MPP_LO 11

// mie and mip share these positions
`define MIE_MSI_BIT 3
`define MIE_MTI_BIT 7
`define MIE_MEI_BIT 11

`endif

// ==== hw/csr_map_pkg.sv ====
`include "csr_settings.svh"

package csr_map_pkg;

    // implemented machine-mode csr indices
    typedef enum logic [`CSR_IDX_W-1:0] {
        // machine information, read-only
        CSR_MVENDORID = 12'hf11,
        CSR_MARCHID   = 12'hf12,
        CSR_MIMPID    = 12'hf13,
        CSR_MHARTID   = 12'hf14,

        // trap setup
        CSR_MSTATUS   = 12'h300,
        CSR_MISA      = 12'h301,
        CSR_MIE       = 12'h304,
        CSR_MTVEC     = 12'h305,

        // trap handling
        CSR_MSCRATCH  = 12'h340,
        CSR_MEPC      = 12'h341,
        CSR_MCAUSE    = 12'h342,
        CSR_MTVAL     = 12'h343,
        CSR_MIP       = 12'h344,

        // counters
        CSR_MCYCLE    = 12'hb00,
        CSR_MCYCLEH   = 12'hb80
    } csr_addr_e;

endpackage

// ==== hw/csr_trap_pkg.sv ====
package csr_trap_pkg;

    // commit event from the core, valid for a single cycle
    typedef enum logic [1:0] {
        // no event this cycle
        TRAP_NONE = 2'd0,
        // synchronous exception, also saves mtval
        TRAP_EXCP = 2'd1,
        // interrupt taken
        TRAP_IRQ  = 2'd2,
        // return from machine-mode handler
        TRAP_MRET = 2'd3
    } trap_evt_e;

endpackage

// ==== hw/csr_access.sv ====
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_access
    import csr_map_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_n,

    input  logic [`CSR_IDX_W-1:0]   csr_idx,
    input  logic                    wbck_vld,
    input  logic [`CSR_XLEN-1:0]    wbck_wdata,

    // assembled words from the register banks
    input  logic [`CSR_XLEN-1:0]    mstatus_word,
    input  logic [`CSR_XLEN-1:0]    mepc_word,
    input  logic [`CSR_XLEN-1:0]    mcause_word,
    input  logic [`CSR_XLEN-1:0]    mtval_word,
    input  logic [`CSR_XLEN-1:0]    mtvec_word,
    input  logic [`CSR_XLEN-1:0]    mie_word,
    input  logic [`CSR_XLEN-1:0]    mip_word,

    output logic                    wr_en,
    output csr_addr_e               wr_idx,
    output logic [`CSR_XLEN-1:0]    wr_data,

    output logic [`CSR_XLEN-1:0]    csr_rdata,
    output logic                    ilegl_access
);

    csr_addr_e                  idx;
    logic                       idx_known;
    logic                       idx_ro;
    logic [`CSR_XLEN-1:0]       mscratch_q;
    logic [`CSR_CYCLE_W-1:0]    mcycle_q;

    assign idx = csr_addr_e'(csr_idx);

    always_comb begin
        idx_known = 1'b1;
        idx_ro = 1'b0;
        case (idx)
            CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID,
            CSR_MISA, CSR_MIP, CSR_MCYCLE, CSR_MCYCLEH: begin
                idx_ro = 1'b1;
            end
            CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH,
            CSR_MEPC, CSR_MCAUSE, CSR_MTVAL: begin
                idx_ro = 1'b0;
            end
            default: begin
                idx_known = 1'b0;
            end
        endcase
    end

    // unknown index is flagged on read as well as write
    assign ilegl_access = ~idx_known | (wbck_vld & idx_ro);

    assign wr_en = wbck_vld & idx_known & ~idx_ro;
    assign wr_idx = idx;
    assign wr_data = wbck_wdata;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mscratch_q <= '0;
        end else if (wr_en && (wr_idx == CSR_MSCRATCH)) begin
            mscratch_q <= wr_data;
        end
    end

    // free-running, counts every cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mcycle_q <= '0;
        end else begin
            mcycle_q <= mcycle_q + 1'b1;
        end
    end

    always_comb begin
        case (idx)
            CSR_MSTATUS:  csr_rdata = mstatus_word;
            CSR_MIE:      csr_rdata = mie_word;
            CSR_MTVEC:    csr_rdata = mtvec_word;
            CSR_MSCRATCH: csr_rdata = mscratch_q;
            CSR_MEPC:     csr_rdata = mepc_word;
            CSR_MCAUSE:   csr_rdata = mcause_word;
            CSR_MTVAL:    csr_rdata = mtval_word;
            CSR_MIP:      csr_rdata = mip_word;
            CSR_MCYCLE:   csr_rdata = mcycle_q[`CSR_XLEN-1:0];
            CSR_MCYCLEH:  csr_rdata = mcycle_q[`CSR_CYCLE_W-1:`CSR_XLEN];
            // ids, misa and unknown indices
            default:      csr_rdata = '0;
        endcase
    end

endmodule

// ==== hw/csr_trap_regs.sv ====
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_trap_regs
    import csr_map_pkg::*;
    import csr_trap_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_n,

    input  logic [`CSR_XLEN-1:0]    reset_mtvec,

    input  logic                    wr_en,
    input  csr_addr_e               wr_idx,
    input  logic [`CSR_XLEN-1:0]    wr_data,

    input  trap_evt_e               cmt_evt,
    input  logic [`CSR_XLEN-1:0]    cmt_mepc,
    input  logic [`CSR_XLEN-1:0]    cmt_mcause,
    input  logic [`CSR_XLEN-1:0]    cmt_mtval,

    output logic [`CSR_XLEN-1:0]    mstatus_word,
    output logic [`CSR_XLEN-1:0]    mepc_word,
    output logic [`CSR_XLEN-1:0]    mcause_word,
    output logic [`CSR_XLEN-1:0]    mtval_word,
    output logic [`CSR_XLEN-1:0]    mtvec_word,
    output logic                    mstatus_mie
);

    logic   trap_vld;
    logic   mie_q;
    logic   mpie_q;

    assign trap_vld = (cmt_evt == TRAP_EXCP) || (cmt_evt == TRAP_IRQ);

    // commit events take priority over a write-back in the same cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mie_q <= 1'b0;
            mpie_q <= 1'b0;
        end else if (trap_vld) begin
            mpie_q <= mie_q;
            mie_q <= 1'b0;
        end else if (cmt_evt == TRAP_MRET) begin
            mie_q <= mpie_q;
            mpie_q <= 1'b1;
        end else if (wr_en && (wr_idx == CSR_MSTATUS)) begin
            mie_q <= wr_data[`MSTATUS_MIE_BIT];
            mpie_q <= wr_data[`MSTATUS_MPIE_BIT];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mepc_word <= '0;
            mcause_word <= '0;
        end else if (trap_vld) begin
            mepc_word <= cmt_mepc;
            mcause_word <= cmt_mcause;
        end else if (wr_en) begin
            if (wr_idx == CSR_MEPC) begin
                mepc_word <= wr_data;
            end
            if (wr_idx == CSR_MCAUSE) begin
                mcause_word <= wr_data;
            end
        end
    end

    // interrupts leave mtval alone
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mtval_word <= '0;
        end else if (cmt_evt == TRAP_EXCP) begin
            mtval_word <= cmt_mtval;
        end else if (wr_en && (wr_idx == CSR_MTVAL)) begin
            mtval_word <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mtvec_word <= reset_mtvec;
        end else if (wr_en && (wr_idx == CSR_MTVEC)) begin
            mtvec_word <= wr_data;
        end
    end

    // machine mode only, so MPP stays at 3
    always_comb begin
        mstatus_word = '0;
        mstatus_word[`MSTATUS_MPP_LO +: 2] = 2'b11;
        mstatus_word[`MSTATUS_MPIE_BIT] = mpie_q;
        mstatus_word[`MSTATUS_MIE_BIT] = mie_q;
    end

    assign mstatus_mie = mie_q;

endmodule

// ==== hw/csr_irq_regs.sv ====
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_irq_regs
    import csr_map_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_n,

    input  logic                    wr_en,
    input  csr_addr_e               wr_idx,
    input  logic [`CSR_XLEN-1:0]    wr_data,

    input  logic                    sft_irq,
    input  logic                    tmr_irq,
    input  logic                    ext_irq,

    output logic [`CSR_XLEN-1:0]    mie_word,
    output logic [`CSR_XLEN-1:0]    mip_word,
    output logic                    sft_irq_en,
    output logic                    tmr_irq_en,
    output logic                    ext_irq_en
);

    // ordered sft, tmr, ext from bit 0
    logic [2:0]     en_q;
    logic [2:0]     pend_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            en_q <= '0;
        end else if (wr_en && (wr_idx == CSR_MIE)) begin
            en_q <= {wr_data[`MIE_MEI_BIT], wr_data[`MIE_MTI_BIT], wr_data[`MIE_MSI_BIT]};
        end
    end

    // lines sampled once, one edge of lag
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pend_q <= '0;
        end else begin
            pend_q <= {ext_irq, tmr_irq, sft_irq};
        end
    end

    always_comb begin
        mie_word = '0;
        mie_word[`MIE_MSI_BIT] = en_q[0];
        mie_word[`MIE_MTI_BIT] = en_q[1];
        mie_word[`MIE_MEI_BIT] = en_q[2];
        mip_word = '0;
        mip_word[`MIE_MSI_BIT] = pend_q[0];
        mip_word[`MIE_MTI_BIT] = pend_q[1];
        mip_word[`MIE_MEI_BIT] = pend_q[2];
    end

    assign sft_irq_en = en_q[0];
    assign tmr_irq_en = en_q[1];
    assign ext_irq_en = en_q[2];

endmodule

// ==== hw/csr_file.sv ====
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_file
    import csr_map_pkg::*;
    import csr_trap_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic [`CSR_XLEN-1:0]    reset_mtvec,

    input  logic                    sft_irq,
    input  logic                    tmr_irq,
    input  logic                    ext_irq,

    input  trap_evt_e               cmt_evt,
    input  logic [`CSR_XLEN-1:0]    cmt_mepc,
    input  logic [`CSR_XLEN-1:0]    cmt_mcause,
    input  logic [`CSR_XLEN-1:0]    cmt_mtval,

    input  logic [`CSR_IDX_W-1:0]   csr_idx,
    input  logic                    wbck_vld,
    input  logic [`CSR_XLEN-1:0]    wbck_wdata,
    output logic [`CSR_XLEN-1:0]    csr_rdata,
    output logic                    ilegl_access,

    output logic [`CSR_XLEN-1:0]    mtvec,
    output logic [`CSR_XLEN-1:0]    mepc,
    output logic                    mstatus_mie,
    output logic                    sft_irq_en,
    output logic                    tmr_irq_en,
    output logic                    ext_irq_en
);

    logic                       wr_en;
    csr_addr_e                  wr_idx;
    logic [`CSR_XLEN-1:0]       wr_data;
    logic [`CSR_XLEN-1:0]       mstatus_word;
    logic [`CSR_XLEN-1:0]       mcause_word;
    logic [`CSR_XLEN-1:0]       mtval_word;
    logic [`CSR_XLEN-1:0]       mie_word;
    logic [`CSR_XLEN-1:0]       mip_word;

    csr_access i_access (
        .clk          (clk),
        .reset_n      (reset_n),
        .csr_idx      (csr_idx),
        .wbck_vld     (wbck_vld),
        .wbck_wdata   (wbck_wdata),
        .mstatus_word (mstatus_word),
        .mepc_word    (mepc),
        .mcause_word  (mcause_word),
        .mtval_word   (mtval_word),
        .mtvec_word   (mtvec),
        .mie_word     (mie_word),
        .mip_word     (mip_word),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .wr_data      (wr_data),
        .csr_rdata    (csr_rdata),
        .ilegl_access (ilegl_access)
    );

    csr_trap_regs i_trap_regs (
        .clk          (clk),
        .reset_n      (reset_n),
        .reset_mtvec  (reset_mtvec),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .wr_data      (wr_data),
        .cmt_evt      (cmt_evt),
        .cmt_mepc     (cmt_mepc),
        .cmt_mcause   (cmt_mcause),
        .cmt_mtval    (cmt_mtval),
        .mstatus_word (mstatus_word),
        .mepc_word    (mepc),
        .mcause_word  (mcause_word),
        .mtval_word   (mtval_word),
        .mtvec_word   (mtvec),
        .mstatus_mie  (mstatus_mie)
    );

    csr_irq_regs i_irq_regs (
        .clk        (clk),
        .reset_n    (reset_n),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_data    (wr_data),
        .sft_irq    (sft_irq),
        .tmr_irq    (tmr_irq),
        .ext_irq    (ext_irq),
        .mie_word   (mie_word),
        .mip_word   (mip_word),
        .sft_irq_en (sft_irq_en),
        .tmr_irq_en (tmr_irq_en),
        .ext_irq_en (ext_irq_en)
    );

endmodule

// ==== bench/tb_csr_file.sv ====
`timescale 1ns/1ps
`include "csr_settings.svh"

module tb_csr_file
    import csr_map_pkg::*;
    import csr_trap_pkg::*;
();

    localparam logic [31:0] RESET_MTVEC = 32'h8000_0040;
    localparam logic [31:0] IE_MASK = (32'h1 << `MIE_MSI_BIT) | (32'h1 << `MIE_MTI_BIT)
                                    | (32'h1 << `MIE_MEI_BIT);

    logic clk, reset_n;
    logic sft_irq, tmr_irq, ext_irq;
    trap_evt_e cmt_evt;
    logic [31:0] cmt_mepc, cmt_mcause, cmt_mtval, wbck_wdata, csr_rdata, mtvec, mepc;
    logic [11:0] csr_idx;
    logic wbck_vld, ilegl_access, mstatus_mie, sft_irq_en, tmr_irq_en, ext_irq_en;

    // shadow state of the CSR file
    logic m_mie, m_mpie;
    logic [31:0] m_mepc, m_mcause, m_mtval, m_mtvec, m_mscratch, m_ie;
    logic [63:0] cyc_cnt, cyc_off;

    // compare request from the stimulus
    logic chk_vld, chk_wr;
    logic [11:0] chk_idx;
    string chk_tag;
    int ack_cnt = 0;
    int check_cnt = 0;
    int err_cnt = 0;
    int test_chk_base = 0;
    int test_err_base = 0;
    logic [31:0] lfsr_q = 32'd12;
    logic [31:0] c1, c2;

    // writable csrs for the read-back test
    logic [11:0] idx_list_w [7] = '{12'h305, 12'h340, 12'h341, 12'h342, 12'h343, 12'h304,
                                    12'h300};

    csr_file i_dut (
        .clk(clk), .reset_n(reset_n), .reset_mtvec(RESET_MTVEC),
        .sft_irq(sft_irq), .tmr_irq(tmr_irq), .ext_irq(ext_irq),
        .cmt_evt(cmt_evt), .cmt_mepc(cmt_mepc), .cmt_mcause(cmt_mcause), .cmt_mtval(cmt_mtval),
        .csr_idx(csr_idx), .wbck_vld(wbck_vld), .wbck_wdata(wbck_wdata),
        .csr_rdata(csr_rdata), .ilegl_access(ilegl_access), .mtvec(mtvec), .mepc(mepc),
        .mstatus_mie(mstatus_mie), .sft_irq_en(sft_irq_en), .tmr_irq_en(tmr_irq_en),
        .ext_irq_en(ext_irq_en)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // time reference for mcycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cyc_cnt <= '0;
        end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'ha300_0000;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit
    function logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return r;
    endfunction

    function automatic logic is_illegal(input logic [11:0] idx, input logic wr);
        logic known, ro;
        ro = idx inside {12'hf11, 12'hf12, 12'hf13, 12'hf14, 12'h301, 12'h344, 12'hb00, 12'hb80};
        known = ro || (idx inside {12'h300, 12'h304, 12'h305, 12'h340, 12'h341, 12'h342, 12'h343});
        return !known || (wr && ro);
    endfunction

    function logic [31:0] csr_model_read(input logic [11:0] idx);
        logic [63:0] cyc;
        logic [31:0] r;
        cyc = cyc_cnt + cyc_off;
        r = '0;
        case (idx)
            CSR_MSTATUS: begin
                r[`MSTATUS_MPP_LO +: 2] = 2'b11;
                r[`MSTATUS_MPIE_BIT] = m_mpie;
                r[`MSTATUS_MIE_BIT] = m_mie;
            end
            CSR_MIE:      r = m_ie;
            CSR_MTVEC:    r = m_mtvec;
            CSR_MSCRATCH: r = m_mscratch;
            CSR_MEPC:     r = m_mepc;
            CSR_MCAUSE:   r = m_mcause;
            CSR_MTVAL:    r = m_mtval;
            CSR_MIP: begin
                r[`MIE_MSI_BIT] = sft_irq;
                r[`MIE_MTI_BIT] = tmr_irq;
                r[`MIE_MEI_BIT] = ext_irq;
            end
            CSR_MCYCLE:   r = cyc[31:0];
            CSR_MCYCLEH:  r = cyc[63:32];
            default:      r = '0;
        endcase
        return r;
    endfunction

    task model_write(input logic [11:0] idx, input logic [31:0] data);
        if (!is_illegal(idx, 1'b1)) begin
            case (idx)
                CSR_MSTATUS: begin
                    m_mie = data[`MSTATUS_MIE_BIT];
                    m_mpie = data[`MSTATUS_MPIE_BIT];
                end
                CSR_MIE:      m_ie = data & IE_MASK;
                CSR_MTVEC:    m_mtvec = data;
                CSR_MSCRATCH: m_mscratch = data;
                CSR_MEPC:     m_mepc = data;
                CSR_MCAUSE:   m_mcause = data;
                CSR_MTVAL:    m_mtval = data;
                default: ;
            endcase
        end
    endtask

    always @(negedge clk) begin : compare
        logic [31:0] exp_rd;
        if (chk_vld) begin
            exp_rd = csr_model_read(chk_idx);
            assert (csr_rdata === exp_rd) else begin
                $display("** Error at %0t: %s, csr %h read %h, expected %h",
                         $time, chk_tag, chk_idx, csr_rdata, exp_rd);
                err_cnt++;
            end
            assert (ilegl_access === is_illegal(chk_idx, chk_wr)) else begin
                $display("** Error at %0t: %s, csr %h ilegl_access %b", $time, chk_tag,
                         chk_idx, ilegl_access);
                err_cnt++;
            end
            assert (mtvec === m_mtvec && mepc === m_mepc && mstatus_mie === m_mie
                    && {ext_irq_en, tmr_irq_en, sft_irq_en} === {m_ie[`MIE_MEI_BIT],
                    m_ie[`MIE_MTI_BIT], m_ie[`MIE_MSI_BIT]}) else begin
                $display("** Error at %0t: %s, mirrored outputs differ from model",
                         $time, chk_tag);
                err_cnt++;
            end
            check_cnt++;
            ack_cnt++;
        end
    end

    task issue_access(input logic [11:0] idx, input logic wr, input logic [31:0] data,
                      input string tag);
        int want;
        int t;
        want = ack_cnt + 1;
        @(posedge clk);
        csr_idx <= idx;
        wbck_vld <= wr;
        wbck_wdata <= data;
        chk_idx <= idx;
        chk_wr <= wr;
        chk_tag = tag;
        chk_vld <= 1'b1;
        t = 0;
        @(posedge clk);
        while (ack_cnt != want && t < 8) begin
            @(posedge clk);
            t++;
        end
        wbck_vld <= 1'b0;
        chk_vld <= 1'b0;
        if (ack_cnt != want) begin
            $display("timeout: compare process never answered for %s", tag);
            $display("*** TEST FAILED ***");
            $finish;
        end else if (wr) begin
            model_write(idx, data);
        end
    endtask

    // optional write-back in the same cycle as the commit event
    task commit_event(input trap_evt_e evt, input logic wr, input logic [11:0] widx,
                      input logic [31:0] wdata);
        logic old_mie, old_mpie;
        logic [31:0] pc, cause, tval;
        pc = rand_bits(32);
        cause = rand_bits(32);
        tval = rand_bits(32);
        @(posedge clk);
        cmt_evt <= evt;
        cmt_mepc <= pc;
        cmt_mcause <= cause;
        cmt_mtval <= tval;
        csr_idx <= widx;
        wbck_wdata <= wdata;
        wbck_vld <= wr;
        @(posedge clk);
        cmt_evt <= TRAP_NONE;
        wbck_vld <= 1'b0;
        old_mie = m_mie;
        old_mpie = m_mpie;
        if (wr) begin
            model_write(widx, wdata);
        end
        if (evt == TRAP_EXCP || evt == TRAP_IRQ) begin
            m_mepc = pc;
            m_mcause = cause;
            m_mpie = old_mie;
            m_mie = 1'b0;
            if (evt == TRAP_EXCP) begin
                m_mtval = tval;
            end
        end else if (evt == TRAP_MRET) begin
            m_mie = old_mpie;
            m_mpie = 1'b1;
        end
    endtask

    task read_all(input string tag);
        logic [11:0] idx_list [15];
        idx_list = '{12'h300, 12'h301, 12'h304, 12'h305, 12'h340, 12'h341, 12'h342, 12'h343,
                     12'h344, 12'hb00, 12'hb80, 12'hf11, 12'hf12, 12'hf13, 12'hf14};
        foreach (idx_list[i]) begin
            issue_access(idx_list[i], 1'b0, '0, tag);
        end
    endtask

    task finish_test(input string name);
        $display("test %s: %0d checks, %0d errors", name, check_cnt - test_chk_base,
                 err_cnt - test_err_base);
        test_chk_base = check_cnt;
        test_err_base = err_cnt;
    endtask

    initial begin
        reset_n = 1'b0;
        {sft_irq, tmr_irq, ext_irq, wbck_vld, chk_vld, chk_wr} = '0;
        {cmt_mepc, cmt_mcause, cmt_mtval, wbck_wdata} = '0;
        cmt_evt = TRAP_NONE;
        csr_idx = '0;
        chk_idx = '0;
        {m_mie, m_mpie, m_mepc, m_mcause, m_mtval, m_mscratch, m_ie, cyc_off} = '0;
        m_mtvec = RESET_MTVEC;
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;

        // fixed offset between the bench count and mcycle
        @(posedge clk);
        csr_idx <= CSR_MCYCLE;
        @(negedge clk);
        cyc_off = {32'h0, csr_rdata} - cyc_cnt;

        read_all("reset");
        finish_test("reset");

        foreach (idx_list_w[i]) begin
            issue_access(idx_list_w[i], 1'b1, rand_bits(32), "write");
        end
        read_all("write readback");
        finish_test("write and read-back");

        issue_access(CSR_MSTATUS, 1'b1, 32'h1 << `MSTATUS_MIE_BIT, "set mie");
        commit_event(TRAP_EXCP, 1'b0, CSR_MEPC, '0);
        read_all("exception");
        issue_access(CSR_MSTATUS, 1'b1, 32'h1 << `MSTATUS_MIE_BIT, "set mie");
        commit_event(TRAP_IRQ, 1'b0, CSR_MEPC, '0);
        read_all("interrupt");
        commit_event(TRAP_EXCP, 1'b1, CSR_MEPC, rand_bits(32));
        read_all("trap against mepc write");
        finish_test("trap entry");

        commit_event(TRAP_MRET, 1'b0, CSR_MSTATUS, '0);
        issue_access(CSR_MSTATUS, 1'b0, '0, "mret");
        commit_event(TRAP_MRET, 1'b1, CSR_MSTATUS, '0);
        issue_access(CSR_MSTATUS, 1'b0, '0, "mret against mstatus write");
        finish_test("mret");

        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            {ext_irq, tmr_irq, sft_irq} <= (i < 3) ? 3'b001 << i : {3{i == 3}};
            issue_access(CSR_MIP, 1'b0, '0, "pending");
        end
        finish_test("pending interrupts");

        issue_access(12'h7c0, 1'b0, '0, "unknown read");
        issue_access(12'h7c0, 1'b1, rand_bits(32), "unknown write");
        issue_access(CSR_MIP, 1'b1, rand_bits(32), "mip write");
        issue_access(CSR_MCYCLE, 1'b1, rand_bits(32), "mcycle write");
        read_all("after illegal");
        @(posedge clk);
        csr_idx <= CSR_MCYCLE;
        @(negedge clk);
        c1 = csr_rdata;
        repeat (17) @(negedge clk);
        c2 = csr_rdata;
        check_cnt++;
        assert (c2 - c1 == 32'd17) else begin
            $display("** Error at %0t: mcycle moved by %0d over 17 cycles", $time, c2 - c1);
            err_cnt++;
        end
        finish_test("illegal access and mcycle");

        $display("checks %0d, errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+hw
hw/csr_map_pkg.sv
hw/csr_trap_pkg.sv
hw/csr_access.sv
hw/csr_trap_regs.sv
hw/csr_irq_regs.sv
hw/csr_file.sv
bench/tb_csr_file.sv

// ==== Bender.yml ====
package:
  name: csr_file

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/csr_map_pkg.sv
      - hw/csr_trap_pkg.sv
      - hw/csr_access.sv
      - hw/csr_trap_regs.sv
      - hw/csr_irq_regs.sv
      - hw/csr_file.sv

  - target: test
    include_dirs:
      - hw
    files:
      - bench/tb_csr_file.sv
